//--- src/adc_ctrl_params.svh
`ifndef ADC_CTRL_PARAMS_SVH
`define ADC_CTRL_PARAMS_SVH

// Width of one converter sample
`define ADC_DATA_W 10

// Channels sampled in turn, channel 0 first
`define ADC_NUM_CHN 2

// Window filters evaluated on every sampled pair
`define ADC_NUM_FILTERS 4

// Power-up wait field, counted in always-on clock cycles
`define ADC_PWRUP_W 4

// Consecutive stable pairs needed before a match is reported
`define ADC_SAMPLE_CNT_W 16

`endif

//--- src/adc_ctrl_ast_pkg.sv
`default_nettype none

`include "adc_ctrl_params.svh"

package adc_ctrl_ast_pkg;

  // One raw conversion result
  typedef logic [`ADC_DATA_W-1:0] adc_data_t;

  // Controller to converter
  // channel_sel is one-hot while a sample is requested, zero otherwise
  typedef struct packed {
    logic                    pd;
    logic [`ADC_NUM_CHN-1:0] channel_sel;
  } adc_req_t;

  // Converter to controller
  // data_valid acknowledges the select and stays high until the select drops
  typedef struct packed {
    adc_data_t data;
    logic      data_valid;
  } adc_rsp_t;

endpackage

`default_nettype wire

//--- src/adc_ctrl_cfg_pkg.sv
`default_nettype none

`include "adc_ctrl_params.svh"

package adc_ctrl_cfg_pkg;

  typedef enum logic [3:0] {
    PWRDN,
    PWRUP,
    ONEST_0,
    ONEST_021,
    ONEST_1,
    ONEST_DONE,
    NP_0,
    NP_021,
    NP_1,
    NP_EVAL,
    NP_DONE
  } adc_seq_state_e;

  // cond selects the sense of the window: 0 inside, 1 outside
  typedef struct packed {
    logic [`ADC_DATA_W-1:0] min_v;
    logic [`ADC_DATA_W-1:0] max_v;
    logic                   cond;
    logic                   en;
  } adc_filter_cfg_t;

  typedef struct packed {
    logic                         enable;
    logic                         oneshot_mode;
    logic                         fsm_rst;
    logic [`ADC_PWRUP_W-1:0]      pwrup_time;
    logic [`ADC_SAMPLE_CNT_W-1:0] np_sample_cnt;
    logic [`ADC_NUM_FILTERS-1:0]  match_en;
  } adc_cfg_t;

  // Indexed as [channel][filter]
  typedef adc_filter_cfg_t [`ADC_NUM_CHN-1:0][`ADC_NUM_FILTERS-1:0] adc_filter_set_t;

  typedef struct packed {
    logic [`ADC_NUM_FILTERS-1:0] match;
    logic                        oneshot;
  } adc_status_t;

  typedef adc_ctrl_ast_pkg::adc_data_t [`ADC_NUM_CHN-1:0] adc_chn_vals_t;

endpackage

`default_nettype wire

//--- src/adc_ctrl_seq.sv
`default_nettype none

`include "adc_ctrl_params.svh"

module adc_ctrl_seq (
  input  logic                        clk_aon_i,
  input  logic                        rst_aon_ni,
  input  adc_ctrl_cfg_pkg::adc_cfg_t  cfg_i,
  input  adc_ctrl_ast_pkg::adc_rsp_t  adc_rsp_i,
  input  logic [`ADC_NUM_FILTERS-1:0] match_i,
  output adc_ctrl_ast_pkg::adc_req_t  adc_req_o,
  output logic [`ADC_NUM_CHN-1:0]     capture_o,
  output logic                        np_done_o,
  output logic                        oneshot_done_o
);
  import adc_ctrl_cfg_pkg::*;

  adc_seq_state_e state_q;
  adc_seq_state_e state_d;

  logic enable_q;
  logic trig_rise;
  logic trig_fall;
  logic seq_clr;
  logic dval;

  logic [`ADC_PWRUP_W-1:0]      pwrup_cnt_q;
  logic                         pwrup_cnt_en;
  logic                         pwrup_cnt_clr;
  logic [`ADC_SAMPLE_CNT_W-1:0] np_cnt_q;
  logic [`ADC_SAMPLE_CNT_W-1:0] np_cnt_thresh;
  logic                         np_cnt_en;
  logic                         np_cnt_clr;

  logic [`ADC_NUM_FILTERS-1:0] match_q;
  logic                        ld_match;
  logic                        stay;

  assign dval = adc_rsp_i.data_valid;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      enable_q <= 1'b0;
    end else if (cfg_i.fsm_rst) begin
      enable_q <= 1'b0;
    end else begin
      enable_q <= cfg_i.enable;
    end
  end

  assign trig_rise = ~enable_q & cfg_i.enable;
  assign trig_fall = enable_q & ~cfg_i.enable;
  assign seq_clr   = cfg_i.fsm_rst | trig_fall;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q     <= PWRDN;
      pwrup_cnt_q <= '0;
      np_cnt_q    <= '0;
    end else if (seq_clr) begin
      state_q     <= PWRDN;
      pwrup_cnt_q <= '0;
      np_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      if (pwrup_cnt_clr) begin
        pwrup_cnt_q <= '0;
      end else if (pwrup_cnt_en) begin
        pwrup_cnt_q <= pwrup_cnt_q + 1'b1;
      end
      if (np_cnt_clr) begin
        np_cnt_q <= '0;
      end else if (np_cnt_en) begin
        np_cnt_q <= np_cnt_q + 1'b1;
      end
    end
  end

  // Previous pair's match vector, only fsm_rst wipes it
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      match_q <= '0;
    end else if (cfg_i.fsm_rst) begin
      match_q <= '0;
    end else if (ld_match) begin
      match_q <= match_i;
    end
  end

  assign stay          = (|match_i) & ((match_i == match_q) | ~(|match_q));
  assign np_cnt_thresh = cfg_i.np_sample_cnt - 1'b1;

  assign capture_o[0] = dval & ((state_q == ONEST_0) | (state_q == NP_0));
  assign capture_o[1] = dval & ((state_q == ONEST_1) | (state_q == NP_1));

  always_comb begin
    state_d                = state_q;
    adc_req_o.pd           = 1'b0;
    adc_req_o.channel_sel  = '0;
    pwrup_cnt_en           = 1'b0;
    pwrup_cnt_clr          = 1'b0;
    np_cnt_en              = 1'b0;
    np_cnt_clr             = 1'b0;
    ld_match               = 1'b0;
    np_done_o              = 1'b0;
    oneshot_done_o         = 1'b0;

    unique case (state_q)
      PWRDN: begin
        adc_req_o.pd = 1'b1;
        if (trig_rise) state_d = PWRUP;
      end
      PWRUP: begin
        if (pwrup_cnt_q != cfg_i.pwrup_time) begin
          pwrup_cnt_en = 1'b1;
        end else begin
          pwrup_cnt_clr = 1'b1;
          state_d       = cfg_i.oneshot_mode ? ONEST_0 : NP_0;
        end
      end
      ONEST_0, NP_0: begin
        adc_req_o.channel_sel = 2'b01;
        if (dval) state_d = (state_q == ONEST_0) ? ONEST_021 : NP_021;
      end
      // Wait for the converter to release data valid before the next request
      ONEST_021, NP_021: begin
        if (!dval) state_d = (state_q == ONEST_021) ? ONEST_1 : NP_1;
      end
      ONEST_1, NP_1: begin
        adc_req_o.channel_sel = 2'b10;
        if (dval) state_d = (state_q == ONEST_1) ? ONEST_DONE : NP_EVAL;
      end
      ONEST_DONE: begin
        oneshot_done_o = 1'b1;
        state_d        = PWRDN;
      end
      NP_EVAL: begin
        if (!dval) begin
          ld_match = 1'b1;
          state_d  = NP_0;
          if (!stay) begin
            np_cnt_clr = 1'b1;
          end else if (np_cnt_q < np_cnt_thresh) begin
            np_cnt_en = 1'b1;
          end else if (np_cnt_q == np_cnt_thresh) begin
            // Counting past the threshold keeps a long run from firing again
            np_cnt_en = 1'b1;
            state_d   = NP_DONE;
          end
        end
      end
      NP_DONE: begin
        np_done_o = 1'b1;
        state_d   = NP_0;
      end
      default: state_d = PWRDN;
    endcase
  end

endmodule

`default_nettype wire

//--- src/adc_ctrl_filter.sv
`default_nettype none

`include "adc_ctrl_params.svh"

module adc_ctrl_filter (
  input  logic                              clk_aon_i,
  input  logic                              rst_aon_ni,
  input  logic                              fsm_rst_i,
  input  logic [`ADC_NUM_CHN-1:0]           capture_i,
  input  adc_ctrl_ast_pkg::adc_data_t       adc_data_i,
  input  adc_ctrl_cfg_pkg::adc_filter_set_t filters_i,
  output adc_ctrl_cfg_pkg::adc_chn_vals_t   chn_vals_o,
  output logic [`ADC_NUM_FILTERS-1:0]       match_o
);
  import adc_ctrl_cfg_pkg::*;

  adc_chn_vals_t vals_q;

  // True when one channel's value satisfies one filter's window and sense
  function automatic logic chn_hit(input logic [`ADC_DATA_W-1:0] val,
                                   input adc_filter_cfg_t        flt);
    logic in_win;
    in_win = (val >= flt.min_v) && (val <= flt.max_v);
    return in_win ^ flt.cond;
  endfunction

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      vals_q <= '0;
    end else if (fsm_rst_i) begin
      vals_q <= '0;
    end else begin
      for (int c = 0; c < `ADC_NUM_CHN; c++) begin
        if (capture_i[c]) begin
          vals_q[c] <= adc_data_i;
        end
      end
    end
  end

  assign chn_vals_o = vals_q;

  // A filter with no enabled channel never matches
  always_comb begin
    logic any_en;
    logic all_hit;
    match_o = '0;
    for (int f = 0; f < `ADC_NUM_FILTERS; f++) begin
      any_en  = 1'b0;
      all_hit = 1'b1;
      for (int c = 0; c < `ADC_NUM_CHN; c++) begin
        if (filters_i[c][f].en) begin
          any_en = 1'b1;
          if (!chn_hit(vals_q[c], filters_i[c][f])) begin
            all_hit = 1'b0;
          end
        end
      end
      match_o[f] = any_en & all_hit;
    end
  end

endmodule

`default_nettype wire

//--- src/adc_ctrl_status.sv
`default_nettype none

`include "adc_ctrl_params.svh"

module adc_ctrl_status (
  input  logic                          clk_aon_i,
  input  logic                          rst_aon_ni,
  input  logic                          np_done_i,
  input  logic                          oneshot_done_i,
  input  logic [`ADC_NUM_FILTERS-1:0]   match_i,
  input  logic [`ADC_NUM_FILTERS-1:0]   match_en_i,
  input  adc_ctrl_cfg_pkg::adc_status_t clear_i,
  output adc_ctrl_cfg_pkg::adc_status_t status_o,
  output logic                          intr_o,
  output logic                          wkup_req_o
);
  import adc_ctrl_cfg_pkg::*;

  adc_status_t status_q;
  adc_status_t status_d;

  // New events win over a clear landing in the same cycle
  always_comb begin
    status_d.match   = status_q.match & ~clear_i.match;
    status_d.oneshot = status_q.oneshot & ~clear_i.oneshot;
    if (np_done_i) begin
      status_d.match = status_d.match | match_i;
    end
    if (oneshot_done_i) begin
      status_d.oneshot = 1'b1;
    end
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign status_o   = status_q;
  assign intr_o     = |status_q;
  assign wkup_req_o = |(status_q.match & match_en_i);

endmodule

`default_nettype wire

//--- src/adc_ctrl.sv
`default_nettype none

`include "adc_ctrl_params.svh"

module adc_ctrl (
  input  logic                              clk_aon_i,
  input  logic                              rst_aon_ni,
  input  adc_ctrl_cfg_pkg::adc_cfg_t        cfg_i,
  input  adc_ctrl_cfg_pkg::adc_filter_set_t filters_i,
  input  adc_ctrl_cfg_pkg::adc_status_t     clear_i,
  input  adc_ctrl_ast_pkg::adc_rsp_t        adc_i,
  output adc_ctrl_ast_pkg::adc_req_t        adc_o,
  output adc_ctrl_cfg_pkg::adc_chn_vals_t   chn_vals_o,
  output adc_ctrl_cfg_pkg::adc_status_t     status_o,
  output logic                              intr_o,
  output logic                              wkup_req_o
);

  logic [`ADC_NUM_CHN-1:0]     capture;
  logic [`ADC_NUM_FILTERS-1:0] match;
  logic                        np_done;
  logic                        oneshot_done;

  adc_ctrl_seq u_seq (
    .clk_aon_i      (clk_aon_i),
    .rst_aon_ni     (rst_aon_ni),
    .cfg_i          (cfg_i),
    .adc_rsp_i      (adc_i),
    .match_i        (match),
    .adc_req_o      (adc_o),
    .capture_o      (capture),
    .np_done_o      (np_done),
    .oneshot_done_o (oneshot_done)
  );

  adc_ctrl_filter u_filter (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .fsm_rst_i  (cfg_i.fsm_rst),
    .capture_i  (capture),
    .adc_data_i (adc_i.data),
    .filters_i  (filters_i),
    .chn_vals_o (chn_vals_o),
    .match_o    (match)
  );

  adc_ctrl_status u_status (
    .clk_aon_i      (clk_aon_i),
    .rst_aon_ni     (rst_aon_ni),
    .np_done_i      (np_done),
    .oneshot_done_i (oneshot_done),
    .match_i        (match),
    .match_en_i     (cfg_i.match_en),
    .clear_i        (clear_i),
    .status_o       (status_o),
    .intr_o         (intr_o),
    .wkup_req_o     (wkup_req_o)
  );

endmodule

`default_nettype wire

//--- test/adc_ctrl_properties.sv
`default_nettype none

module adc_ctrl_properties (
  input logic                       clk_aon_i,
  input logic                       rst_aon_ni,
  input adc_ctrl_cfg_pkg::adc_cfg_t cfg_i,
  input adc_ctrl_ast_pkg::adc_rsp_t adc_i,
  input adc_ctrl_ast_pkg::adc_req_t adc_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fails = 0;

  sel_onehot_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    $onehot0(adc_o.channel_sel))
  else begin
    $error("channel select has more than one bit set");
    assert_fails++;
  end

  pd_no_sel_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    adc_o.pd |-> adc_o.channel_sel == '0)
  else begin
    $error("channel select raised while the converter is powered down");
    assert_fails++;
  end

  // An enable drop or fsm_rst may end a request before the acknowledge
  sel_hold_a: assert property (@(posedge clk_aon_i) disable iff (!rst_aon_ni)
    (adc_o.channel_sel != '0) && !adc_i.data_valid && cfg_i.enable && !cfg_i.fsm_rst
    |=> adc_o.channel_sel == $past(adc_o.channel_sel))
  else begin
    $error("channel select changed before data valid");
    assert_fails++;
  end

endmodule

bind adc_ctrl adc_ctrl_properties u_props (
  .clk_aon_i  (clk_aon_i),
  .rst_aon_ni (rst_aon_ni),
  .cfg_i      (cfg_i),
  .adc_i      (adc_i),
  .adc_o      (adc_o)
);

`default_nettype wire

//--- test/tb_adc_ctrl.sv
`default_nettype none

`include "adc_ctrl_params.svh"

module tb_adc_ctrl;
  timeunit 1ns;
  timeprecision 1ps;
  import adc_ctrl_ast_pkg::*;
  import adc_ctrl_cfg_pkg::*;

  localparam int RST_CYCLES   = 16;
  localparam int ONESHOT_RUNS = 4;
  localparam int IDLE_PAIRS   = 8;
  // One sample takes at most 6 cycles to acknowledge plus 3 to release
  localparam int PAIR_MAX     = 2 * 12 + 2;
  localparam int RUN_SETUP    = 16 + 8;
  localparam int MAX_CYCLES   = 2 * (RST_CYCLES + 2
                                + ONESHOT_RUNS * (RUN_SETUP + PAIR_MAX)
                                + RUN_SETUP + 4 * PAIR_MAX + 8
                                + RUN_SETUP + IDLE_PAIRS * PAIR_MAX
                                + 2 * (RUN_SETUP + PAIR_MAX));

  logic            clk_aon_i;
  logic            rst_aon_ni;
  adc_cfg_t        cfg_i;
  adc_filter_set_t filters_i;
  adc_status_t     clear_i;
  adc_rsp_t        adc_i;
  adc_req_t        adc_o;
  adc_chn_vals_t   chn_vals_o;
  adc_status_t     status_o;
  logic            intr_o;
  logic            wkup_req_o;

  int            seed = 32'hddee;
  int            resp_seed = 32'hddee;
  int            errors = 0;
  int            checks = 0;
  int            tests = 0;
  int            test_errs = 0;
  int            cycle_cnt = 0;
  int            chn1_reqs = 0;
  int            req_log[$];
  logic          resp_busy;
  adc_data_t     chn_q0[$];
  adc_data_t     chn_q1[$];
  // Returned for a channel whose queue is empty
  adc_chn_vals_t hold_vals;

  adc_ctrl u_adc_ctrl (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .cfg_i      (cfg_i),
    .filters_i  (filters_i),
    .clear_i    (clear_i),
    .adc_i      (adc_i),
    .adc_o      (adc_o),
    .chn_vals_o (chn_vals_o),
    .status_o   (status_o),
    .intr_o     (intr_o),
    .wkup_req_o (wkup_req_o)
  );

  // Window rule counted per filter as enabled channels against satisfied ones
  function automatic logic [`ADC_NUM_FILTERS-1:0] model_match(input adc_filter_set_t flt,
                                                              input adc_chn_vals_t   vals);
    logic [`ADC_NUM_FILTERS-1:0] m;
    int   n_en;
    int   n_ok;
    logic in_range;
    m = '0;
    for (int f = 0; f < `ADC_NUM_FILTERS; f++) begin
      n_en = 0;
      n_ok = 0;
      for (int c = 0; c < `ADC_NUM_CHN; c++) begin
        in_range = (vals[c] >= flt[c][f].min_v) && (vals[c] <= flt[c][f].max_v);
        n_en += flt[c][f].en;
        n_ok += flt[c][f].en && (in_range != flt[c][f].cond);
      end
      m[f] = (n_en > 0) && (n_ok == n_en);
    end
    return m;
  endfunction

  // Pairs until np_done when every pair gives the same vector or 0 when it never fires
  function automatic int pairs_to_done(input logic [`ADC_NUM_FILTERS-1:0] m, input int n);
    logic [`ADC_NUM_FILTERS-1:0] prev;
    int cnt;
    prev = '0;
    cnt  = 0;
    for (int p = 1; p <= 64; p++) begin
      if (m != 0 && (m == prev || prev == 0)) begin
        if (cnt == n - 1) return p;
        cnt++;
      end else begin
        cnt = 0;
      end
      prev = m;
    end
    return 0;
  endfunction

  task automatic next_cycle();
    @(posedge clk_aon_i);
    #2;
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] t=%0t %s", $time, msg);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) report_fail($sformatf("%s got %b exp %b", name, got, exp));
  endtask

  task automatic check_vals(input adc_chn_vals_t got, input adc_chn_vals_t exp);
    checks++;
    if (got !== exp) report_fail($sformatf("chn_vals got %h exp %h", got, exp));
  endtask

  task automatic check_status(input adc_status_t got, input adc_status_t exp);
    checks++;
    if (got !== exp) report_fail($sformatf("status got %h exp %h", got, exp));
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_errs) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  task automatic go_idle();
    cfg_i.enable = 1'b0;
    next_cycle();
    while (resp_busy) next_cycle();
  endtask

  task automatic clear_status(input adc_status_t mask);
    clear_i = mask;
    next_cycle();
    clear_i = '0;
    next_cycle();
  endtask

  task automatic random_filters();
    adc_data_t a;
    adc_data_t b;
    for (int c = 0; c < `ADC_NUM_CHN; c++) begin
      for (int f = 0; f < `ADC_NUM_FILTERS; f++) begin
        a = $random(seed);
        b = $random(seed);
        filters_i[c][f].min_v = (a < b) ? a : b;
        filters_i[c][f].max_v = (a < b) ? b : a;
        filters_i[c][f].cond  = $random(seed);
        filters_i[c][f].en    = $random(seed);
      end
    end
  endtask

  initial begin : clock_gen
    clk_aon_i = 1'b0;
    forever #20 clk_aon_i = ~clk_aon_i;
  end

  initial begin : watchdog
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_aon_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

  // Converter model answering one select at a time
  initial begin : responder
    int ch;
    int dly;
    adc_i     = '0;
    resp_busy = 1'b0;
    forever begin
      next_cycle();
      if (adc_o.channel_sel != '0 && !adc_i.data_valid) begin
        resp_busy = 1'b1;
        ch = adc_o.channel_sel[1] ? 1 : 0;
        req_log.push_back(ch);
        if (ch == 1) chn1_reqs++;
        dly = 1 + $unsigned($random(resp_seed)) % 6;
        repeat (dly) next_cycle();
        if (ch == 0 && chn_q0.size() > 0) hold_vals[0] = chn_q0.pop_front();
        if (ch == 1 && chn_q1.size() > 0) hold_vals[1] = chn_q1.pop_front();
        adc_i.data       = hold_vals[ch];
        adc_i.data_valid = 1'b1;
        while (adc_o.channel_sel != '0) next_cycle();
        dly = 1 + $unsigned($random(resp_seed)) % 3;
        repeat (dly) next_cycle();
        adc_i.data_valid = 1'b0;
        resp_busy        = 1'b0;
      end
    end
  end

  initial begin : main
    adc_status_t                 exp_st;
    adc_chn_vals_t               exp_vals;
    logic [`ADC_NUM_FILTERS-1:0] exp_m;
    adc_status_t                 clr;
    int                          n_smp;
    int                          exp_pairs;
    adc_data_t                   v;
    cfg_i      = '0;
    filters_i  = '0;
    clear_i    = '0;
    hold_vals  = '0;
    rst_aon_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_aon_i);
    #2 rst_aon_ni = 1'b1;

    next_cycle();
    check_bit("pd", adc_o.pd, 1'b1);
    check_bit("select zero", adc_o.channel_sel == '0, 1'b1);
    check_status(status_o, '0);
    check_bit("intr", intr_o, 1'b0);
    check_bit("wkup_req", wkup_req_o, 1'b0);
    end_test("reset values");

    for (int r = 0; r < ONESHOT_RUNS; r++) begin
      clear_status('1);
      exp_vals[0] = $random(seed);
      exp_vals[1] = $random(seed);
      chn_q0.push_back(exp_vals[0]);
      chn_q1.push_back(exp_vals[1]);
      req_log.delete();
      cfg_i.oneshot_mode = 1'b1;
      cfg_i.pwrup_time   = $random(seed);
      cfg_i.enable       = 1'b1;
      next_cycle();
      while (!status_o.oneshot) next_cycle();
      exp_st         = '0;
      exp_st.oneshot = 1'b1;
      check_vals(chn_vals_o, exp_vals);
      check_status(status_o, exp_st);
      check_bit("intr", intr_o, 1'b1);
      check_bit("pd", adc_o.pd, 1'b1);
      if (req_log.size() != 2 || req_log[0] != 0 || req_log[1] != 1) begin
        report_fail("channel 0 was not requested before channel 1");
      end
      go_idle();
    end
    end_test("one-shot sampling");

    clear_status('1);
    random_filters();
    hold_vals[0] = $random(seed);
    hold_vals[1] = $random(seed);
    exp_m = model_match(filters_i, hold_vals);
    // Make filter 0 a full-range window on channel 0 so something matches
    if (exp_m == '0) begin
      filters_i[0][0] = '{min_v: '0, max_v: '1, cond: 1'b0, en: 1'b1};
      filters_i[1][0].en = 1'b0;
      exp_m = model_match(filters_i, hold_vals);
    end
    n_smp     = 1 + $unsigned($random(seed)) % 4;
    exp_pairs = pairs_to_done(exp_m, n_smp);
    chn1_reqs = 0;
    cfg_i.oneshot_mode  = 1'b0;
    cfg_i.np_sample_cnt = n_smp;
    cfg_i.match_en      = $random(seed);
    cfg_i.enable        = 1'b1;
    next_cycle();
    while (status_o.match == '0) next_cycle();
    if (chn1_reqs != exp_pairs) begin
      report_fail($sformatf("match after %0d pairs exp %0d", chn1_reqs, exp_pairs));
    end
    exp_st       = '0;
    exp_st.match = exp_m;
    check_status(status_o, exp_st);
    check_bit("intr", intr_o, 1'b1);
    end_test("normal mode match");

    check_bit("wkup_req", wkup_req_o, |(exp_m & cfg_i.match_en));
    clr       = '0;
    clr.match = $random(seed);
    clear_status(clr);
    exp_st.match = exp_m & ~clr.match;
    check_status(status_o, exp_st);
    check_bit("intr", intr_o, |exp_st);
    check_bit("wkup_req", wkup_req_o, |(exp_st.match & cfg_i.match_en));
    clear_status('1);
    check_status(status_o, '0);
    check_bit("intr", intr_o, 1'b0);
    check_bit("wkup_req", wkup_req_o, 1'b0);
    end_test("wake request and clear");
    go_idle();

    // Channel 0 sits just above a one-value window on every filter
    v = $unsigned($random(seed)) % 1000;
    for (int f = 0; f < `ADC_NUM_FILTERS; f++) begin
      filters_i[0][f] = '{min_v: v, max_v: v, cond: 1'b0, en: 1'b1};
    end
    hold_vals[0] = v + 1;
    hold_vals[1] = $random(seed);
    exp_st       = '0;
    exp_st.match = model_match(filters_i, hold_vals);
    chn1_reqs    = 0;
    cfg_i.np_sample_cnt = 1;
    cfg_i.enable        = 1'b1;
    while (chn1_reqs < IDLE_PAIRS) next_cycle();
    check_status(status_o, exp_st);
    check_bit("intr", intr_o, 1'b0);
    end_test("normal mode without match");
    go_idle();

    hold_vals[0] = $random(seed) | 1;
    hold_vals[1] = $random(seed) | 1;
    cfg_i.enable = 1'b1;
    while (adc_o.channel_sel == '0) next_cycle();
    cfg_i.enable = 1'b0;
    next_cycle();
    check_bit("pd", adc_o.pd, 1'b1);
    check_bit("select zero", adc_o.channel_sel == '0, 1'b1);
    go_idle();
    chn1_reqs    = 0;
    cfg_i.enable = 1'b1;
    while (chn1_reqs == 0) next_cycle();
    cfg_i.fsm_rst = 1'b1;
    next_cycle();
    check_bit("pd", adc_o.pd, 1'b1);
    check_bit("select zero", adc_o.channel_sel == '0, 1'b1);
    check_vals(chn_vals_o, '0);
    cfg_i.fsm_rst = 1'b0;
    go_idle();
    end_test("abort by enable and fsm_rst");

    if (u_adc_ctrl.u_props.assert_fails != 0) begin
      $display("%0d assertion failures in the bound properties",
               u_adc_ctrl.u_props.assert_fails);
      errors += u_adc_ctrl.u_props.assert_fails;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- adc_ctrl.f
+incdir+src
src/adc_ctrl_ast_pkg.sv
src/adc_ctrl_cfg_pkg.sv
src/adc_ctrl_seq.sv
src/adc_ctrl_filter.sv
src/adc_ctrl_status.sv
src/adc_ctrl.sv
test/adc_ctrl_properties.sv
test/tb_adc_ctrl.sv

//--- Bender.yml
package:
  name: adc_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/adc_ctrl_ast_pkg.sv
      - src/adc_ctrl_cfg_pkg.sv
      - src/adc_ctrl_seq.sv
      - src/adc_ctrl_filter.sv
      - src/adc_ctrl_status.sv
      - src/adc_ctrl.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/adc_ctrl_properties.sv
      - test/tb_adc_ctrl.sv
